//--- Bender.yml
package:
  name: rx_frame

sources:
  - files:
      - rtl/rx_pkg.sv
      - rtl/signal_field_collector.sv
      - rtl/fcs_crc32.sv
      - rtl/rx_control.sv
      - rtl/rx_report.sv
      - rtl/rx_frame_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_rx_frame.sv

//--- rtl/fcs_crc32.sv
module fcs_crc32 import rx_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  logic        clear_i,
    input  logic [7:0]  byte_i,
    input  logic        byte_valid_i,
    output logic [31:0] crc_o
);

    logic [31:0] crc_base;

    // one byte, lsb first, reflected register
    function automatic logic [31:0] crc_byte(logic [31:0] crc_in, logic [7:0] data);
        logic [31:0] crc;
        crc = crc_in;
        for (int i = 0; i < 8; i++) begin
            if (crc[0] ^ data[i]) begin
                crc = (crc >> 1) ^ fcs_poly;
            end else begin
                crc = crc >> 1;
            end
        end
        return crc;
    endfunction

    // a byte arriving with clear starts from the preset
    assign crc_base = clear_i ? '1 : crc_o;

    always_ff @(posedge clock) begin
        if (reset) begin
            crc_o <= '1;
        end else if (byte_valid_i) begin
            crc_o <= crc_byte(crc_base, byte_i);
        end else if (clear_i) begin
            crc_o <= '1;
        end
    end

endmodule

//--- rtl/rx_control.sv
module rx_control import rx_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  logic        frame_start_i,
    input  logic        byte_valid_i,
    input  logic        signal_ready_i,
    input  rate_t       rate_i,
    input  legacy_len_t len_i,
    input  logic        rsvd_i,
    input  logic [5:0]  tail_i,
    input  logic        parity_ok_i,
    input  logic [31:0] fcs_value_i,
    output logic        collect_en_o,
    output logic        fcs_clear_o,
    output logic        data_byte_valid_o,
    output logic        header_strobe_o,
    output logic        header_ok_o,
    output logic        frame_end_o,
    output logic        fcs_pass_o,
    output status_t     status_o,
    output rx_state_t   state_o
);

    rx_state_t   state;
    byte_count_t bytes_left;
    status_t     hdr_status;
    logic        hdr_pass;
    logic        take_first;
    logic        take_next;
    logic        fcs_match;

    //////////////////////////////
    // header checks
    //////////////////////////////

    // first failing check wins
    always_comb begin
        if (!parity_ok_i) begin
            hdr_status = st_parity_fail;
        end else if (rsvd_i) begin
            hdr_status = st_wrong_rsvd;
        end else if (|tail_i) begin
            hdr_status = st_wrong_tail;
        end else if (!rate_i[3]) begin
            hdr_status = st_unsupported_rate;
        end else begin
            hdr_status = st_ok;
        end
    end

    assign hdr_pass = (hdr_status == st_ok);

    //////////////////////////////
    // data byte acceptance
    //////////////////////////////

    // a byte can follow the SIGNAL field while the header is checked
    assign take_first = (state == s_check_signal) && hdr_pass && (len_i != '0);
    assign take_next  = (state == s_decode_data) && (bytes_left != '0);

    assign data_byte_valid_o = byte_valid_i && (take_first || take_next);

    // restart the CRC on the way into data decoding
    assign fcs_clear_o = (state == s_check_signal) && hdr_pass;

    assign collect_en_o = (state == s_collect_signal);
    assign state_o      = state;
    assign fcs_match    = (fcs_value_i == fcs_residue);

    //////////////////////////////
    // packet FSM
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            state           <= s_idle;
            bytes_left      <= '0;
            header_strobe_o <= 1'b0;
            header_ok_o     <= 1'b0;
            frame_end_o     <= 1'b0;
            fcs_pass_o      <= 1'b0;
            status_o        <= st_ok;
        end else begin
            header_strobe_o <= 1'b0;
            frame_end_o     <= 1'b0;

            case (state)
                s_idle: begin
                    if (frame_start_i) begin
                        state <= s_collect_signal;
                    end
                end

                s_collect_signal: begin
                    if (signal_ready_i) begin
                        state <= s_check_signal;
                    end
                end

                s_check_signal: begin
                    header_strobe_o <= 1'b1;
                    header_ok_o     <= hdr_pass;
                    status_o        <= hdr_status;
                    if (hdr_pass) begin
                        // countdown already covers a byte taken this cycle
                        bytes_left <= byte_count_t'(len_i)
                                      - byte_count_t'(data_byte_valid_o);
                        state      <= s_decode_data;
                    end else begin
                        state <= s_signal_error;
                    end
                end

                s_signal_error: begin
                    state <= s_idle;
                end

                s_decode_data: begin
                    if (data_byte_valid_o) begin
                        bytes_left <= bytes_left - 16'd1;
                    end
                    // zero left, one cycle for the last CRC update
                    if (bytes_left == '0) begin
                        state <= s_decode_done;
                    end
                end

                s_decode_done: begin
                    frame_end_o <= 1'b1;
                    fcs_pass_o  <= fcs_match;
                    status_o    <= fcs_match ? st_ok : st_wrong_fcs;
                    state       <= s_idle;
                end

                default: begin
                    state <= s_idle;
                end
            endcase
        end
    end

endmodule

//--- rtl/rx_frame_top.sv
module rx_frame_top import rx_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  logic        frame_start_i,
    input  logic [7:0]  byte_i,
    input  logic        byte_valid_i,
    output logic        pkt_header_strobe_o,
    output logic        pkt_header_valid_o,
    output rate_t       pkt_rate_o,
    output legacy_len_t pkt_len_o,
    output byte_count_t pkt_len_total_o,
    output logic [7:0]  data_byte_o,
    output logic        data_byte_valid_o,
    output byte_count_t byte_count_o,
    output byte_count_t byte_count_total_o,
    output logic        fcs_out_strobe_o,
    output logic        fcs_ok_o,
    output status_t     status_o
);

    logic        collect_en;
    logic        signal_ready;
    rate_t       sig_rate;
    legacy_len_t sig_len;
    logic        sig_rsvd;
    logic [5:0]  sig_tail;
    logic        sig_parity_ok;
    logic        fcs_clear;
    logic        data_byte_valid;
    logic [31:0] fcs_value;
    logic        header_strobe;
    logic        header_ok;
    logic        frame_end;
    logic        fcs_pass;
    status_t     ctrl_status;
    rx_state_t   ctrl_state;

    //////////////////////////////
    // input side
    //////////////////////////////

    signal_field_collector u_collector (
        .clock          (clock),
        .reset          (reset),
        .collect_en_i   (collect_en),
        .byte_i         (byte_i),
        .byte_valid_i   (byte_valid_i),
        .signal_ready_o (signal_ready),
        .rate_o         (sig_rate),
        .len_o          (sig_len),
        .rsvd_o         (sig_rsvd),
        .tail_o         (sig_tail),
        .parity_ok_o    (sig_parity_ok)
    );

    //////////////////////////////
    // packet control and FCS
    //////////////////////////////

    rx_control u_control (
        .clock             (clock),
        .reset             (reset),
        .frame_start_i     (frame_start_i),
        .byte_valid_i      (byte_valid_i),
        .signal_ready_i    (signal_ready),
        .rate_i            (sig_rate),
        .len_i             (sig_len),
        .rsvd_i            (sig_rsvd),
        .tail_i            (sig_tail),
        .parity_ok_i       (sig_parity_ok),
        .fcs_value_i       (fcs_value),
        .collect_en_o      (collect_en),
        .fcs_clear_o       (fcs_clear),
        .data_byte_valid_o (data_byte_valid),
        .header_strobe_o   (header_strobe),
        .header_ok_o       (header_ok),
        .frame_end_o       (frame_end),
        .fcs_pass_o        (fcs_pass),
        .status_o          (ctrl_status),
        .state_o           (ctrl_state)
    );

    fcs_crc32 u_fcs (
        .clock        (clock),
        .reset        (reset),
        .clear_i      (fcs_clear),
        .byte_i       (byte_i),
        .byte_valid_i (data_byte_valid),
        .crc_o        (fcs_value)
    );

    //////////////////////////////
    // output side
    //////////////////////////////

    rx_report u_report (
        .clock               (clock),
        .reset               (reset),
        .state_i             (ctrl_state),
        .header_strobe_i     (header_strobe),
        .header_ok_i         (header_ok),
        .rate_i              (sig_rate),
        .len_i               (sig_len),
        .data_byte_valid_i   (data_byte_valid),
        .byte_i              (byte_i),
        .frame_end_i         (frame_end),
        .fcs_pass_i          (fcs_pass),
        .status_i            (ctrl_status),
        .pkt_header_strobe_o (pkt_header_strobe_o),
        .pkt_header_valid_o  (pkt_header_valid_o),
        .pkt_rate_o          (pkt_rate_o),
        .pkt_len_o           (pkt_len_o),
        .pkt_len_total_o     (pkt_len_total_o),
        .data_byte_o         (data_byte_o),
        .data_byte_valid_o   (data_byte_valid_o),
        .byte_count_o        (byte_count_o),
        .byte_count_total_o  (byte_count_total_o),
        .fcs_out_strobe_o    (fcs_out_strobe_o),
        .fcs_ok_o            (fcs_ok_o),
        .status_o            (status_o)
    );

endmodule

//--- rtl/rx_pkg.sv
package rx_pkg;

    //////////////////////////////
    // legacy SIGNAL field
    //////////////////////////////

    typedef logic [3:0]  rate_t;
    typedef logic [11:0] legacy_len_t;

    // first received byte lands in bits 7..0
    typedef struct packed {
        logic [5:0]  tail;
        logic        parity;
        legacy_len_t length;
        logic        reserved;
        rate_t       rate;
    } signal_field_t;

    // number of bytes in the SIGNAL field
    localparam int unsigned signal_bytes = 3;

    //////////////////////////////
    // status and control
    //////////////////////////////

    typedef enum logic [3:0] {
        st_ok               = 4'd0,
        st_parity_fail      = 4'd1,
        st_wrong_rsvd       = 4'd2,
        st_wrong_tail       = 4'd3,
        st_unsupported_rate = 4'd4,
        st_wrong_fcs        = 4'd5
    } status_t;

    typedef enum logic [2:0] {
        s_idle,
        s_collect_signal,
        s_check_signal,
        s_signal_error,
        s_decode_data,
        s_decode_done
    } rx_state_t;

    typedef logic [15:0] byte_count_t;

    //////////////////////////////
    // frame check sequence
    //////////////////////////////

    // reflected form of the 802.3 polynomial
    localparam logic [31:0] fcs_poly    = 32'hEDB88320;
    // register contents after data plus a good FCS
    localparam logic [31:0] fcs_residue = 32'hDEBB20E3;

endpackage

//--- rtl/rx_report.sv
module rx_report import rx_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  rx_state_t   state_i,
    input  logic        header_strobe_i,
    input  logic        header_ok_i,
    input  rate_t       rate_i,
    input  legacy_len_t len_i,
    input  logic        data_byte_valid_i,
    input  logic [7:0]  byte_i,
    input  logic        frame_end_i,
    input  logic        fcs_pass_i,
    input  status_t     status_i,
    output logic        pkt_header_strobe_o,
    output logic        pkt_header_valid_o,
    output rate_t       pkt_rate_o,
    output legacy_len_t pkt_len_o,
    output byte_count_t pkt_len_total_o,
    output logic [7:0]  data_byte_o,
    output logic        data_byte_valid_o,
    output byte_count_t byte_count_o,
    output byte_count_t byte_count_total_o,
    output logic        fcs_out_strobe_o,
    output logic        fcs_ok_o,
    output status_t     status_o
);

    logic [7:0] byte_q;
    logic [7:0] byte_qq;
    logic       byte_stb_q;
    logic       byte_stb_qq;

    //////////////////////////////
    // header and frame result
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            pkt_header_strobe_o <= 1'b0;
            pkt_header_valid_o  <= 1'b0;
            fcs_out_strobe_o    <= 1'b0;
            fcs_ok_o            <= 1'b0;
            status_o            <= st_ok;
        end else begin
            pkt_header_strobe_o <= header_strobe_i;
            fcs_out_strobe_o    <= frame_end_i;
            if (header_strobe_i) begin
                pkt_header_valid_o <= header_ok_i;
                fcs_ok_o           <= 1'b0;
                status_o           <= status_i;
            end else if (frame_end_i) begin
                pkt_header_valid_o <= 1'b0;
                fcs_ok_o           <= fcs_pass_i;
                status_o           <= status_i;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (header_strobe_i) begin
            pkt_rate_o      <= rate_i;
            pkt_len_o       <= len_i;
            pkt_len_total_o <= byte_count_t'(len_i) + byte_count_t'(signal_bytes);
        end
    end

    //////////////////////////////
    // data byte stream
    //////////////////////////////

    // capture from the shared bus, then one stage before the output
    always_ff @(posedge clock) begin
        byte_q      <= byte_i;
        byte_qq     <= byte_q;
        data_byte_o <= byte_qq;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            byte_stb_q         <= 1'b0;
            byte_stb_qq        <= 1'b0;
            data_byte_valid_o  <= 1'b0;
            byte_count_o       <= '0;
            byte_count_total_o <= '0;
        end else begin
            byte_stb_q        <= data_byte_valid_i;
            byte_stb_qq       <= byte_stb_q;
            data_byte_valid_o <= byte_stb_qq;
            if (state_i == s_idle) begin
                byte_count_o       <= '0;
                byte_count_total_o <= '0;
            end else if (header_strobe_i) begin
                // SIGNAL bytes count toward the total
                byte_count_total_o <= byte_count_t'(signal_bytes);
            end else if (byte_stb_qq) begin
                byte_count_o       <= byte_count_o + 16'd1;
                byte_count_total_o <= byte_count_total_o + 16'd1;
            end
        end
    end

endmodule

//--- rtl/signal_field_collector.sv
module signal_field_collector import rx_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  logic        collect_en_i,
    input  logic [7:0]  byte_i,
    input  logic        byte_valid_i,
    output logic        signal_ready_o,
    output rate_t       rate_o,
    output legacy_len_t len_o,
    output logic        rsvd_o,
    output logic [5:0]  tail_o,
    output logic        parity_ok_o
);

    localparam logic [1:0] last_idx = 2'(signal_bytes - 1);
    localparam logic [1:0] full_cnt = 2'(signal_bytes);

    logic [1:0]    byte_cnt;
    signal_field_t sig_word;

    // byte counter and ready pulse
    always_ff @(posedge clock) begin
        if (reset) begin
            byte_cnt       <= '0;
            signal_ready_o <= 1'b0;
        end else begin
            signal_ready_o <= 1'b0;
            if (!collect_en_i) begin
                byte_cnt <= '0;
            end else if (byte_valid_i && byte_cnt != full_cnt) begin
                byte_cnt       <= byte_cnt + 2'd1;
                signal_ready_o <= (byte_cnt == last_idx);
            end
        end
    end

    // newest byte enters at the top
    always_ff @(posedge clock) begin
        if (collect_en_i && byte_valid_i && byte_cnt != full_cnt) begin
            sig_word <= {byte_i, sig_word[23:8]};
        end
    end

    //////////////////////////////
    // field decode
    //////////////////////////////

    assign rate_o = sig_word.rate;
    assign len_o  = sig_word.length;
    assign rsvd_o = sig_word.reserved;
    assign tail_o = sig_word.tail;

    // even number of ones over bits 17..0
    assign parity_ok_o = ~^sig_word[17:0];

endmodule

//--- test/rx_ref_model.svh
`ifndef RX_REF_MODEL_SVH
`define RX_REF_MODEL_SVH

// reflected CRC-32 polynomial, same value as the DUT uses
localparam logic [31:0] ref_poly = 32'hEDB88320;

// parity bit that gives an even count of ones over bits 17..0
function automatic logic ref_parity(input logic [16:0] bits);
    int ones;
    ones = 0;
    for (int i = 0; i < 17; i++) begin
        ones += int'(bits[i]);
    end
    return ones[0];
endfunction

function automatic logic [23:0] build_signal(input rate_t rate, input logic rsvd,
                                             input legacy_len_t len, input logic [5:0] tail,
                                             input logic flip_parity);
    logic [16:0] low;
    low = {len, rsvd, rate};
    return {tail, ref_parity(low) ^ flip_parity, low};
endfunction

//////////////////////////////
// frame check sequence
//////////////////////////////

// byte folded in first, then eight shifts
function automatic logic [31:0] crc32_next(input logic [31:0] crc, input logic [7:0] data);
    logic [31:0] r;
    r = crc ^ {24'd0, data};
    for (int i = 0; i < 8; i++) begin
        r = r[0] ? ((r >> 1) ^ ref_poly) : (r >> 1);
    end
    return r;
endfunction

// standard FCS over the first count bytes
function automatic logic [31:0] fcs_of(input logic [7:0] bytes[$], input int count);
    logic [31:0] crc;
    crc = '1;
    for (int i = 0; i < count; i++) begin
        crc = crc32_next(crc, bytes[i]);
    end
    return ~crc;
endfunction

function automatic void append_fcs(ref logic [7:0] bytes[$]);
    logic [31:0] fcs;
    fcs = fcs_of(bytes, bytes.size());
    for (int k = 0; k < 4; k++) begin
        bytes.push_back(fcs[8*k +: 8]);
    end
endfunction

// last four bytes hold the FCS, lsb first
function automatic logic fcs_matches(input logic [7:0] bytes[$]);
    int n;
    n = bytes.size();
    if (n < 4) begin
        return 1'b0;
    end
    return {bytes[n-1], bytes[n-2], bytes[n-3], bytes[n-4]} == fcs_of(bytes, n - 4);
endfunction

// header checks in priority order
function automatic status_t expected_status(input logic [23:0] sig);
    if (ref_parity(sig[16:0]) != sig[17]) begin
        return st_parity_fail;
    end else if (sig[4]) begin
        return st_wrong_rsvd;
    end else if (sig[23:18] != 6'd0) begin
        return st_wrong_tail;
    end else if (!sig[3]) begin
        return st_unsupported_rate;
    end
    return st_ok;
endfunction

`endif

//--- test/tb_rx_frame.sv
module tb_rx_frame import rx_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    `include "rx_ref_model.svh"

    localparam int payload_len    = 20;
    localparam int good_bytes     = 3 + payload_len + 4;
    localparam int error_frames   = 6;
    localparam int junk_bytes     = 2;
    localparam int stray_bytes    = 4;
    localparam int total_bytes    = 3 * good_bytes + error_frames * (3 + junk_bytes)
                                    + stray_bytes;
    localparam int timeout_cycles = 4 * total_bytes + 200;

    typedef struct packed {
        logic        valid;
        rate_t       rate;
        legacy_len_t len;
        status_t     status;
        logic [31:0] cycle;
    } hdr_exp_t;

    typedef struct packed {
        logic    pass;
        status_t status;
    } fcs_exp_t;

    logic        clock;
    logic        reset;
    logic        frame_start_i;
    logic [7:0]  byte_i;
    logic        byte_valid_i;
    logic        pkt_header_strobe_o;
    logic        pkt_header_valid_o;
    rate_t       pkt_rate_o;
    legacy_len_t pkt_len_o;
    byte_count_t pkt_len_total_o;
    logic [7:0]  data_byte_o;
    logic        data_byte_valid_o;
    byte_count_t byte_count_o;
    byte_count_t byte_count_total_o;
    logic        fcs_out_strobe_o;
    logic        fcs_ok_o;
    status_t     status_o;

    int         seed = 55;
    int         cycle_count = 0;
    int         last_drive_cycle = 0;
    string      test_name = "reset";
    hdr_exp_t   hdr_q[$];
    logic [7:0] data_q[$];
    int         data_cycle_q[$];
    fcs_exp_t   fcs_q[$];
    logic       frame_open = 1'b0;
    int         data_idx = 0;

    rx_frame_top DUT (
        .clock               (clock),
        .reset               (reset),
        .frame_start_i       (frame_start_i),
        .byte_i              (byte_i),
        .byte_valid_i        (byte_valid_i),
        .pkt_header_strobe_o (pkt_header_strobe_o),
        .pkt_header_valid_o  (pkt_header_valid_o),
        .pkt_rate_o          (pkt_rate_o),
        .pkt_len_o           (pkt_len_o),
        .pkt_len_total_o     (pkt_len_total_o),
        .data_byte_o         (data_byte_o),
        .data_byte_valid_o   (data_byte_valid_o),
        .byte_count_o        (byte_count_o),
        .byte_count_total_o  (byte_count_total_o),
        .fcs_out_strobe_o    (fcs_out_strobe_o),
        .fcs_ok_o            (fcs_ok_o),
        .status_o            (status_o)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
    end

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            report_failure($sformatf("ERR %s: %s expected 0x%0h, got 0x%0h",
                                     test_name, what, expected, actual));
        end
    endtask

    //////////////////////////////
    // stimulus
    //////////////////////////////

    // idle gap first, then one valid cycle
    task automatic send_byte(input logic [7:0] b);
        int gap;
        gap = 1 + ($unsigned($random(seed)) % 3);
        repeat (gap) @(negedge clock);
        byte_i           = b;
        byte_valid_i     = 1'b1;
        last_drive_cycle = cycle_count;
        @(negedge clock);
        byte_valid_i = 1'b0;
    endtask

    task automatic run_frame(input string name, input logic [23:0] sig,
                             input logic [7:0] body[$]);
        hdr_exp_t hdr;
        fcs_exp_t fin;
        int       third;
        test_name = name;
        @(negedge clock);
        frame_start_i = 1'b1;
        @(negedge clock);
        frame_start_i = 1'b0;
        for (int i = 0; i < 3; i++) begin
            send_byte(sig[8*i +: 8]);
        end
        third      = last_drive_cycle;
        hdr.status = expected_status(sig);
        hdr.valid  = (hdr.status == st_ok);
        hdr.rate   = sig[3:0];
        hdr.len    = sig[16:5];
        // header pipeline is three edges past the sampling edge
        hdr.cycle  = 32'(third + 4);
        hdr_q.push_back(hdr);
        if (hdr.valid) begin
            foreach (body[i]) begin
                data_q.push_back(body[i]);
            end
            fin.pass   = fcs_matches(body);
            fin.status = fin.pass ? st_ok : st_wrong_fcs;
            fcs_q.push_back(fin);
        end
        foreach (body[i]) begin
            send_byte(body[i]);
            // data output two edges past the sampling edge
            if (hdr.valid) begin
                data_cycle_q.push_back(last_drive_cycle + 3);
            end
        end
        while (hdr_q.size() != 0 || data_q.size() != 0 || fcs_q.size() != 0 || frame_open) begin
            @(negedge clock);
        end
        repeat (2) @(negedge clock);
    endtask

    initial begin
        logic [7:0]  payload[$];
        logic [7:0]  corrupt[$];
        logic [7:0]  junk[$];
        logic [23:0] good_sig;
        reset         = 1'b1;
        frame_start_i = 1'b0;
        byte_i        = 8'h00;
        byte_valid_i  = 1'b0;
        repeat (8) @(negedge clock);
        reset = 1'b0;

        for (int i = 0; i < payload_len; i++) begin
            payload.push_back(8'($random(seed)));
        end
        append_fcs(payload);
        for (int i = 0; i < junk_bytes; i++) begin
            junk.push_back(8'($random(seed)));
        end
        good_sig = build_signal(4'b1101, 1'b0, 12'(payload.size()), 6'd0, 1'b0);

        run_frame("good_frame", good_sig, payload);
        corrupt    = payload;
        corrupt[5] = corrupt[5] ^ 8'h10;
        run_frame("corrupt_payload", good_sig, corrupt);

        // no frame start, so nothing may come out
        test_name = "stray_bytes";
        for (int i = 0; i < stray_bytes; i++) begin
            send_byte(8'($random(seed)));
        end
        repeat (6) @(negedge clock);

        run_frame("parity_flip", build_signal(4'b1101, 1'b0, 12'd24, 6'd0, 1'b1), junk);
        run_frame("reserved_set", build_signal(4'b1101, 1'b1, 12'd24, 6'd0, 1'b0), junk);
        run_frame("tail_nonzero", build_signal(4'b1101, 1'b0, 12'd24, 6'h05, 1'b0), junk);
        run_frame("rate_bit3_clear", build_signal(4'b0101, 1'b0, 12'd24, 6'd0, 1'b0), junk);
        run_frame("parity_and_tail", build_signal(4'b1101, 1'b0, 12'd24, 6'h21, 1'b1), junk);
        run_frame("rsvd_and_rate", build_signal(4'b0111, 1'b1, 12'd24, 6'd0, 1'b0), junk);
        run_frame("good_after_error", good_sig, payload);

        repeat (4) @(negedge clock);
        if (hdr_q.size() != 0 || data_q.size() != 0 || fcs_q.size() != 0 || frame_open) begin
            report_failure("expected DUT outputs were still missing at the end of the run");
        end else begin
            $display("All tests passed");
            $finish;
        end
    end

    //////////////////////////////
    // comparison
    //////////////////////////////

    task automatic check_header();
        hdr_exp_t e;
        if (hdr_q.size() == 0) begin
            report_failure($sformatf("%s: header strobe with no frame started", test_name));
        end else begin
            e = hdr_q.pop_front();
            check_value("header cycle", e.cycle, cycle_count);
            check_value("header valid", e.valid, pkt_header_valid_o);
            check_value("header status", e.status, status_o);
            check_value("rate", e.rate, pkt_rate_o);
            check_value("length", e.len, pkt_len_o);
            check_value("total length", 32'(e.len) + 32'd3, pkt_len_total_o);
            frame_open = e.valid;
            data_idx   = 0;
        end
    endtask

    task automatic check_data();
        logic [7:0] b;
        int         due;
        if (!frame_open || data_q.size() == 0) begin
            report_failure($sformatf("%s: data byte came out with no open frame", test_name));
        end else if (data_cycle_q.size() == 0) begin
            report_failure($sformatf("%s: data byte came out before it was sent", test_name));
        end else begin
            b        = data_q.pop_front();
            due      = data_cycle_q.pop_front();
            data_idx = data_idx + 1;
            check_value("data cycle", due, cycle_count);
            check_value("data byte", b, data_byte_o);
            check_value("byte count", data_idx, byte_count_o);
            check_value("total byte count", data_idx + 3, byte_count_total_o);
        end
    endtask

    task automatic check_fcs();
        fcs_exp_t e;
        if (!frame_open || fcs_q.size() == 0) begin
            report_failure($sformatf("%s: FCS strobe without an accepted header", test_name));
        end else if (data_q.size() != 0) begin
            report_failure($sformatf("%s: frame ended before all data bytes came out",
                                     test_name));
        end else begin
            e = fcs_q.pop_front();
            check_value("fcs ok", e.pass, fcs_ok_o);
            check_value("final status", e.status, status_o);
            frame_open = 1'b0;
        end
    endtask

    // outputs are registered, so the falling edge sees them settled
    always @(negedge clock) begin
        if (cycle_count > timeout_cycles) begin
            report_failure($sformatf("timeout after %0d cycles, DUT outputs never arrived",
                                     timeout_cycles));
        end else if (!reset) begin
            if (pkt_header_strobe_o) begin
                check_header();
            end
            if (data_byte_valid_o) begin
                check_data();
            end
            if (fcs_out_strobe_o) begin
                check_fcs();
            end
        end
    end

endmodule

//--- verilog.f
+incdir+test
rtl/rx_pkg.sv
rtl/signal_field_collector.sv
rtl/fcs_crc32.sv
rtl/rx_control.sv
rtl/rx_report.sv
rtl/rx_frame_top.sv
test/tb_rx_frame.sv
